/* logic/rv_isa_pkg.sv */
package rv_isa_pkg;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_u;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_JAL    = 7'b1101111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_t;

  // Arithmetic.
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  // Branches.
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  // Loads and stores.
  localparam logic [2:0] F3_LB      = 3'b000;
  localparam logic [2:0] F3_LW      = 3'b010;
  localparam logic [2:0] F3_LBU     = 3'b100;
  localparam logic [2:0] F3_SB      = 3'b000;
  localparam logic [2:0] F3_SW      = 3'b010;

endpackage

/* logic/core_ctrl_pkg.sv */
package core_ctrl_pkg;

  typedef enum logic [3:0] {
    S_FETCH,
    S_FETCH_WAIT,
    S_DECODE,
    S_EXEC,
    S_MEM,
    S_MEM_WAIT,
    S_WB,
    S_JUMP
  } state_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_t;

  typedef enum logic [1:0] {SRC_A_PC, SRC_A_OLD_PC, SRC_A_RS1, SRC_A_ZERO} src_a_t;
  typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR} src_b_t;
  typedef enum logic [1:0] {RES_ALU_OUT, RES_DATA, RES_ALU_RESULT} result_src_t;

  typedef struct packed {
    logic        pc_write;
    logic        ir_write;
    logic        reg_write;
    logic        adr_is_result;  // Memory address from result, else PC.
    src_a_t      src_a;
    src_b_t      src_b;
    result_src_t result_src;
  } ctrl_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        write;
  } mem_req_t;

endpackage

/* logic/control_fsm.sv */
`timescale 1ns/1ps

module control_fsm (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rv_isa_pkg::opcode_t   opcode,
  input  logic [2:0]            funct3,
  input  logic                  zero,
  input  logic                  mem_ack,
  output core_ctrl_pkg::ctrl_t  ctrl,
  output logic                  mem_valid,
  output core_ctrl_pkg::state_t state
);
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  state_t state_next;
  logic   mem_phase;
  logic   mem_done;
  logic   take_branch;

  assign mem_phase   = (state == S_FETCH) || (state == S_MEM);
  assign mem_done    = mem_phase && mem_valid && mem_ack;  // Data captured this cycle.
  assign take_branch = (funct3 == F3_BNE) ? !zero : zero;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_FETCH;
      mem_valid <= 1'b0;
    end else begin
      state <= state_next;
      if (mem_done) begin
        mem_valid <= 1'b0;
      end else if (mem_phase && !mem_valid && !mem_ack) begin
        mem_valid <= 1'b1;  // Previous ack seen low.
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      S_FETCH:      if (mem_done) state_next = S_FETCH_WAIT;
      S_FETCH_WAIT: if (!mem_ack) state_next = S_DECODE;
      S_DECODE: begin
        case (opcode)
          OP_LUI, OP_IMM, OP_REG, OP_LOAD, OP_STORE, OP_BRANCH: state_next = S_EXEC;
          OP_JAL:  state_next = S_JUMP;
          default: state_next = S_FETCH;  // Unknown opcode is a no-op.
        endcase
      end
      S_EXEC: begin
        case (opcode)
          OP_LOAD, OP_STORE: state_next = S_MEM;
          OP_BRANCH:         state_next = S_FETCH;
          default:           state_next = S_WB;
        endcase
      end
      S_MEM:      if (mem_done) state_next = S_MEM_WAIT;
      S_MEM_WAIT: if (!mem_ack) state_next = (opcode == OP_LOAD) ? S_WB : S_FETCH;
      default:    state_next = S_FETCH;
    endcase
  end

  always_comb begin
    ctrl            = '0;
    ctrl.src_a      = SRC_A_RS1;
    ctrl.src_b      = SRC_B_IMM;
    ctrl.result_src = RES_ALU_OUT;
    case (state)
      S_FETCH: begin
        ctrl.src_a      = SRC_A_PC;
        ctrl.src_b      = SRC_B_FOUR;
        ctrl.result_src = RES_ALU_RESULT;
        ctrl.ir_write   = mem_done;
        ctrl.pc_write   = mem_done;
      end
      S_DECODE: ctrl.src_a = SRC_A_OLD_PC;  // Branch or jump target.
      S_EXEC: begin
        if (opcode == OP_REG || opcode == OP_BRANCH) ctrl.src_b = SRC_B_RS2;
        if (opcode == OP_LUI) ctrl.src_a = SRC_A_ZERO;
        if (opcode == OP_BRANCH) ctrl.pc_write = take_branch;
      end
      S_MEM, S_MEM_WAIT: ctrl.adr_is_result = 1'b1;
      S_WB: begin
        ctrl.reg_write = 1'b1;
        if (opcode == OP_LOAD) ctrl.result_src = RES_DATA;
      end
      S_JUMP: begin
        ctrl.src_a      = SRC_A_OLD_PC;  // Link value.
        ctrl.src_b      = SRC_B_FOUR;
        ctrl.result_src = RES_ALU_RESULT;
        ctrl.reg_write  = 1'b1;
        ctrl.pc_write   = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

/* logic/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode (
  input  rv_isa_pkg::instr_u     instr,
  output rv_isa_pkg::opcode_t    opcode,
  output logic [2:0]             funct3,
  output logic [4:0]             rd,
  output logic [4:0]             rs1,
  output logic [4:0]             rs2,
  output logic [31:0]            imm,
  output core_ctrl_pkg::alu_op_t alu_op
);
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  assign opcode = opcode_t'(instr.r_fmt.opcode);
  assign funct3 = instr.r_fmt.funct3;
  assign rd     = instr.r_fmt.rd;
  assign rs1    = instr.r_fmt.rs1;
  assign rs2    = instr.r_fmt.rs2;

  always_comb begin
    case (opcode)
      OP_LUI:    imm = {instr.u_fmt.imm_31_12, 12'b0};
      OP_JAL:    imm = {{12{instr.j_fmt.imm_20}}, instr.j_fmt.imm_19_12,
                        instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
      OP_BRANCH: imm = {{20{instr.b_fmt.imm_12}}, instr.b_fmt.imm_11,
                        instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
      OP_STORE:  imm = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                        instr.s_fmt.imm_4_0};
      default:   imm = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
    endcase
  end

  always_comb begin
    case (opcode)
      OP_LUI:    alu_op = ALU_PASS_B;
      OP_BRANCH: alu_op = ALU_SUB;  // Compare via zero flag.
      OP_REG, OP_IMM: begin
        case (funct3)
          F3_ADD_SUB: alu_op = (opcode == OP_REG && instr.r_fmt.funct7[5]) ? ALU_SUB : ALU_ADD;
          F3_SLT:     alu_op = ALU_SLT;
          F3_XOR:     alu_op = ALU_XOR;
          F3_OR:      alu_op = ALU_OR;
          F3_AND:     alu_op = ALU_AND;
          default:    alu_op = ALU_ADD;
        endcase
      end
      default:   alu_op = ALU_ADD;
    endcase
  end

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
  input  logic [31:0]            a,
  input  logic [31:0]            b,
  input  core_ctrl_pkg::alu_op_t op,
  output logic [31:0]            y,
  output logic                   zero
);
  import core_ctrl_pkg::*;

  always_comb begin
    case (op)
      ALU_ADD:    y = a + b;
      ALU_SUB:    y = a - b;
      ALU_AND:    y = a & b;
      ALU_OR:     y = a | b;
      ALU_XOR:    y = a ^ b;
      ALU_SLT:    y = {31'b0, $signed(a) < $signed(b)};
      ALU_PASS_B: y = b;
      default:    y = '0;
    endcase
  end

  assign zero = (y == 32'b0);

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file #(
  parameter int NUM_REGS = 32
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        we,
  input  logic [4:0]  ra1,
  input  logic [4:0]  ra2,
  input  logic [4:0]  wa,
  input  logic [31:0] wd,
  output logic [31:0] rd1,
  output logic [31:0] rd2
);
  logic [31:0] regs [NUM_REGS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) regs[i] <= '0;
    end else if (we && wa != 5'd0 && wa < NUM_REGS) begin
      regs[wa] <= wd;
    end
  end

  // x0 and out of range indices read zero.
  assign rd1 = (ra1 != 5'd0 && ra1 < NUM_REGS) ? regs[ra1] : 32'b0;
  assign rd2 = (ra2 != 5'd0 && ra2 < NUM_REGS) ? regs[ra2] : 32'b0;

endmodule

/* logic/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit (
  input  logic [2:0]  funct3,
  input  logic [1:0]  addr_lo,
  input  logic [31:0] rdata,
  input  logic [31:0] store_val,
  output logic [31:0] load_val,
  output logic [31:0] wdata,
  output logic [3:0]  wstrb
);
  import rv_isa_pkg::*;

  logic [7:0] byte_sel;

  assign byte_sel = rdata[8*addr_lo +: 8];

  always_comb begin
    case (funct3)
      F3_LB:   load_val = {{24{byte_sel[7]}}, byte_sel};
      F3_LBU:  load_val = {24'b0, byte_sel};
      F3_LW:   load_val = rdata;
      default: load_val = rdata;
    endcase
  end

  always_comb begin
    case (funct3)
      F3_SB: begin
        wdata = {4{store_val[7:0]}};  // Byte on every lane.
        wstrb = 4'b0001 << addr_lo;
      end
      F3_SW: begin
        wdata = store_val;
        wstrb = 4'b1111;
      end
      default: begin
        wdata = store_val;
        wstrb = 4'b0000;
      end
    endcase
  end

endmodule

/* logic/multicycle_core.sv */
`timescale 1ns/1ps

module multicycle_core #(
  parameter int          NUM_REGS = 32,
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    mem_ack,
  input  logic [31:0]             mem_rdata,
  output core_ctrl_pkg::mem_req_t mem_req,
  output logic                    mem_valid
);
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  ctrl_t       ctrl;
  state_t      state;
  instr_u      instr;
  opcode_t     opcode;
  alu_op_t     dec_alu_op;
  alu_op_t     alu_op;
  logic [2:0]  funct3;
  logic [4:0]  rd, rs1, rs2;
  logic [31:0] imm;
  logic [31:0] pc, old_pc, data, a_q, b_q, alu_out;
  logic [31:0] rd1, rd2, alu_a, alu_b, alu_result, result;
  logic [31:0] load_val, st_wdata;
  logic [3:0]  st_wstrb;
  logic        zero;
  logic        is_store;

  control_fsm u_fsm (
    .clk(clk), .rst_n(rst_n), .opcode(opcode), .funct3(funct3), .zero(zero),
    .mem_ack(mem_ack), .ctrl(ctrl), .mem_valid(mem_valid), .state(state)
  );

  instr_decode u_dec (
    .instr(instr), .opcode(opcode), .funct3(funct3), .rd(rd), .rs1(rs1),
    .rs2(rs2), .imm(imm), .alu_op(dec_alu_op)
  );

  reg_file #(.NUM_REGS(NUM_REGS)) u_rf (
    .clk(clk), .rst_n(rst_n), .we(ctrl.reg_write), .ra1(rs1), .ra2(rs2),
    .wa(rd), .wd(result), .rd1(rd1), .rd2(rd2)
  );

  // Address and target sums outside EXEC.
  assign alu_op = (state == S_EXEC) ? dec_alu_op : ALU_ADD;

  alu u_alu (.a(alu_a), .b(alu_b), .op(alu_op), .y(alu_result), .zero(zero));

  load_store_unit u_lsu (
    .funct3(funct3), .addr_lo(mem_req.addr[1:0]), .rdata(mem_rdata),
    .store_val(b_q), .load_val(load_val), .wdata(st_wdata), .wstrb(st_wstrb)
  );

  always_comb begin
    case (ctrl.src_a)
      SRC_A_PC:     alu_a = pc;
      SRC_A_OLD_PC: alu_a = old_pc;
      SRC_A_RS1:    alu_a = a_q;
      default:      alu_a = 32'b0;
    endcase
    case (ctrl.src_b)
      SRC_B_RS2:  alu_b = b_q;
      SRC_B_IMM:  alu_b = imm;
      SRC_B_FOUR: alu_b = 32'd4;
      default:    alu_b = 32'b0;
    endcase
    case (ctrl.result_src)
      RES_DATA:       result = data;
      RES_ALU_RESULT: result = alu_result;
      default:        result = alu_out;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (ctrl.pc_write) begin
      pc <= ctrl.ir_write ? result : alu_out;  // PC+4 on fetch, else target.
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.ir_write) begin
      instr  <= mem_rdata;
      old_pc <= pc;
    end
    if (mem_valid && mem_ack) data <= load_val;
    a_q     <= rd1;
    b_q     <= rd2;
    alu_out <= alu_result;
  end

  assign is_store = ctrl.adr_is_result && (opcode == OP_STORE);

  always_comb begin
    mem_req.addr  = ctrl.adr_is_result ? result : pc;
    mem_req.wdata = is_store ? st_wdata : 32'b0;
    mem_req.wstrb = is_store ? st_wstrb : 4'b0;
    mem_req.write = is_store;
  end

endmodule

/* verif/core_props.sv */
`timescale 1ns/1ps

module core_props (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    mem_valid,
  input logic                    mem_ack,
  input core_ctrl_pkg::mem_req_t mem_req,
  input logic                    reg_write,
  input core_ctrl_pkg::state_t   state
);
  import core_ctrl_pkg::*;

  int violations = 0;

  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_valid && !mem_ack |=> $stable(mem_req))
    else begin
      $error("mem_req changed while waiting for ack");
      violations++;
    end

  // Ack still high, so no new request yet.
  no_early_valid: assert property (@(posedge clk) disable iff (!rst_n)
    !mem_valid && mem_ack |=> !mem_valid)
    else begin
      $error("mem_valid rose while mem_ack was high");
      violations++;
    end

  write_in_wb: assert property (@(posedge clk) disable iff (!rst_n)
    reg_write |-> state inside {S_WB, S_JUMP})
    else begin
      $error("reg_write asserted outside S_WB and S_JUMP");
      violations++;
    end

endmodule

bind multicycle_core core_props props0 (
  .clk(clk), .rst_n(rst_n), .mem_valid(mem_valid), .mem_ack(mem_ack),
  .mem_req(mem_req), .reg_write(ctrl.reg_write), .state(state)
);

/* verif/core_checker.sv */
`timescale 1ns/1ps

module core_checker (
  input logic                    clk,
  input core_ctrl_pkg::mem_req_t mem_req,
  input logic                    mem_valid,
  input logic                    mem_ack
);
  import rv_isa_pkg::*;

  logic [31:0] ref_mem [1024];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [3:0]  exp_strb [$];
  int          seen_count = 0;
  int          error_count = 0;
  int          expected_total = 0;

  task automatic set_word(input int idx, input logic [31:0] word);
    ref_mem[idx] = word;
  endtask

  function automatic logic [31:0] alu_model(logic [2:0] f3, logic sub,
                                            logic [31:0] a, logic [31:0] b);
    case (f3)
      F3_ADD_SUB: return sub ? a - b : a + b;
      F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F3_XOR:     return a ^ b;
      F3_OR:      return a | b;
      F3_AND:     return a & b;
      default:    return a + b;
    endcase
  endfunction

  // Architectural model that returns the number of executed instructions.
  function automatic int predict_writes(int max_steps);
    logic [31:0] x [32];
    instr_u      ins;
    logic [31:0] pc, next_pc, a, b, imm, addr, val, word;
    logic [7:0]  bval;
    logic        wr;
    logic        done;
    int          steps;
    exp_addr.delete();
    exp_data.delete();
    exp_strb.delete();
    seen_count = 0;
    for (int i = 0; i < 32; i++) x[i] = '0;
    pc    = '0;
    steps = 0;
    done  = 1'b0;
    while (!done && steps < max_steps) begin
      ins     = ref_mem[pc[11:2]];
      steps++;
      a       = x[ins.r_fmt.rs1];
      b       = x[ins.r_fmt.rs2];
      next_pc = pc + 4;
      wr      = 1'b0;
      val     = '0;
      case (ins.r_fmt.opcode)
        OP_LUI: begin
          val = {ins.u_fmt.imm_31_12, 12'b0};
          wr  = 1'b1;
        end
        OP_IMM: begin
          imm = {{20{ins.i_fmt.imm_11_0[11]}}, ins.i_fmt.imm_11_0};
          val = alu_model(ins.i_fmt.funct3, 1'b0, a, imm);
          wr  = 1'b1;
        end
        OP_REG: begin
          val = alu_model(ins.r_fmt.funct3, ins.r_fmt.funct7[5], a, b);
          wr  = 1'b1;
        end
        OP_LOAD: begin
          addr = a + {{20{ins.i_fmt.imm_11_0[11]}}, ins.i_fmt.imm_11_0};
          word = ref_mem[addr[11:2]];
          bval = word[8*addr[1:0] +: 8];
          case (ins.i_fmt.funct3)
            F3_LB:   val = {{24{bval[7]}}, bval};
            F3_LBU:  val = {24'b0, bval};
            default: val = word;
          endcase
          wr = 1'b1;
        end
        OP_STORE: begin
          addr = a + {{20{ins.s_fmt.imm_11_5[6]}}, ins.s_fmt.imm_11_5, ins.s_fmt.imm_4_0};
          exp_addr.push_back(addr);
          if (ins.s_fmt.funct3 == F3_SB) begin
            exp_data.push_back({4{b[7:0]}});
            exp_strb.push_back(4'b0001 << addr[1:0]);
            ref_mem[addr[11:2]][8*addr[1:0] +: 8] = b[7:0];
          end else begin
            exp_data.push_back(b);
            exp_strb.push_back(4'b1111);
            ref_mem[addr[11:2]] = b;
          end
        end
        OP_BRANCH: begin
          imm = {{20{ins.b_fmt.imm_12}}, ins.b_fmt.imm_11, ins.b_fmt.imm_10_5,
                 ins.b_fmt.imm_4_1, 1'b0};
          if ((ins.b_fmt.funct3 == F3_BNE) ? (a != b) : (a == b)) next_pc = pc + imm;
        end
        OP_JAL: begin
          imm = {{12{ins.j_fmt.imm_20}}, ins.j_fmt.imm_19_12, ins.j_fmt.imm_11,
                 ins.j_fmt.imm_10_1, 1'b0};
          done    = (imm == 32'b0);  // Jump to self ends the program.
          val     = pc + 4;
          wr      = 1'b1;
          next_pc = pc + imm;
        end
        default: ;
      endcase
      if (wr && ins.r_fmt.rd != 5'd0) x[ins.r_fmt.rd] = val;
      pc = next_pc;
    end
    expected_total = exp_addr.size();
    return steps;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
      error_count++;
    end
  endtask

  always @(posedge clk) begin
    if (mem_valid && mem_ack && mem_req.write) begin
      seen_count++;
      if (exp_addr.size() == 0) begin
        $display("Unexpected memory write at time %0t to address %h", $time, mem_req.addr);
        error_count++;
      end else begin
        check_value("mem_req.addr", exp_addr.pop_front(), mem_req.addr);
        check_value("mem_req.wdata", exp_data.pop_front(), mem_req.wdata);
        check_value("mem_req.wstrb", {28'b0, exp_strb.pop_front()}, {28'b0, mem_req.wstrb});
      end
    end
  end

endmodule

/* verif/core_tb.sv */
`timescale 1ns/1ps

module core_tb;
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  localparam int MEM_WORDS = 1024;
  localparam int DATA_WORD = 256;  // Data region starts at 0x400.

  logic        clk = 1'b0;
  logic        rst_n;
  logic        mem_ack;
  logic [31:0] mem_rdata;
  mem_req_t    mem_req;
  logic        mem_valid;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] prog [$];
  bit          random_delay;
  bit          pending;
  int          wait_cnt;
  bit          armed;
  time         deadline;
  int          pass_count;
  int          fail_count;

  always #10 clk = ~clk;

  multicycle_core #(.NUM_REGS(32), .RESET_PC(32'h0)) dut0 (
    .clk(clk), .rst_n(rst_n), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
    .mem_req(mem_req), .mem_valid(mem_valid)
  );

  core_checker chk0 (.clk(clk), .mem_req(mem_req), .mem_valid(mem_valid), .mem_ack(mem_ack));

  // Memory model with four-phase handshake.
  always @(negedge clk) begin
    if (!rst_n) begin
      mem_ack = 1'b0;
      pending = 1'b0;
    end else if (mem_valid && !mem_ack) begin
      if (!pending) begin
        pending  = 1'b1;
        wait_cnt = random_delay ? $urandom_range(3, 0) : 0;
      end
      if (wait_cnt == 0) begin
        mem_rdata = mem[mem_req.addr[11:2]];
        if (mem_req.write) begin
          for (int i = 0; i < 4; i++) begin
            if (mem_req.wstrb[i]) mem[mem_req.addr[11:2]][8*i +: 8] = mem_req.wdata[8*i +: 8];
          end
        end
        mem_ack = 1'b1;
      end else begin
        wait_cnt--;
      end
    end else if (!mem_valid && mem_ack) begin
      if (pending) begin
        pending  = 1'b0;  // Ack release delay.
        wait_cnt = random_delay ? $urandom_range(3, 0) : 0;
      end
      if (wait_cnt == 0) begin
        mem_ack = 1'b0;
      end else begin
        wait_cnt--;
      end
    end
  end

  initial begin
    forever begin
      @(posedge clk);
      if (armed && $time > deadline) begin
        $display("Timeout: the core did not finish its stores in time");
        $display("*** TEST FAILED ***");
        $finish;
      end
    end
  end

  function automatic logic [31:0] imm_instr(logic [11:0] imm, logic [4:0] rs1,
                                            logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] reg_instr(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                            logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'(OP_REG)};
  endfunction

  function automatic logic [31:0] store_instr(logic [11:0] imm, logic [4:0] rs2,
                                              logic [4:0] rs1, logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'(OP_STORE)};
  endfunction

  function automatic logic [31:0] branch_instr(logic [12:0] imm, logic [4:0] rs2,
                                               logic [4:0] rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'(OP_BRANCH)};
  endfunction

  function automatic logic [31:0] lui_instr(logic [19:0] imm, logic [4:0] rd);
    return {imm, rd, 7'(OP_LUI)};
  endfunction

  function automatic logic [31:0] jal_instr(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'(OP_JAL)};
  endfunction

  task automatic add_random_alu();
    logic [4:0] rd, rs1, rs2;
    rd  = 5'($urandom_range(30, 1));
    rs1 = 5'($urandom_range(30, 0));
    rs2 = 5'($urandom_range(30, 0));
    case ($urandom_range(6, 0))
      0: prog.push_back(imm_instr(12'($urandom), rs1, F3_ADD_SUB, rd, OP_IMM));
      1: prog.push_back(reg_instr(7'h00, rs2, rs1, F3_ADD_SUB, rd));
      2: prog.push_back(reg_instr(7'h20, rs2, rs1, F3_ADD_SUB, rd));
      3: prog.push_back(reg_instr(7'h00, rs2, rs1, F3_AND, rd));
      4: prog.push_back(reg_instr(7'h00, rs2, rs1, F3_OR, rd));
      5: prog.push_back(reg_instr(7'h00, rs2, rs1, F3_XOR, rd));
      default: prog.push_back(reg_instr(7'h00, rs2, rs1, F3_SLT, rd));
    endcase
  endtask

  task automatic build_arith();
    prog.delete();
    prog.push_back(imm_instr(12'h400, 5'd0, F3_ADD_SUB, 5'd31, OP_IMM));  // Data base in x31.
    for (int r = 1; r <= 15; r++) begin
      prog.push_back(imm_instr(12'($urandom), 5'd0, F3_ADD_SUB, 5'(r), OP_IMM));
    end
    repeat (30) add_random_alu();
    for (int r = 1; r <= 30; r++) prog.push_back(store_instr(12'(4*r), 5'(r), 5'd31, F3_SW));
    prog.push_back(jal_instr(21'd0, 5'd0));
  endtask

  task automatic build_constants();
    prog.delete();
    prog.push_back(imm_instr(12'h400, 5'd0, F3_ADD_SUB, 5'd31, OP_IMM));
    for (int k = 1; k <= 6; k++) begin
      prog.push_back(lui_instr(20'($urandom), 5'(k)));
      prog.push_back(imm_instr(12'($urandom), 5'(k), F3_ADD_SUB, 5'(k), OP_IMM));
    end
    prog.push_back(lui_instr(20'habcde, 5'd0));
    prog.push_back(imm_instr(12'h123, 5'd0, F3_ADD_SUB, 5'd0, OP_IMM));
    for (int k = 0; k <= 6; k++) prog.push_back(store_instr(12'(4*k), 5'(k), 5'd31, F3_SW));
    prog.push_back(jal_instr(21'd0, 5'd0));
  endtask

  task automatic build_bytes();
    logic [7:0] bval;
    prog.delete();
    prog.push_back(imm_instr(12'h400, 5'd0, F3_ADD_SUB, 5'd31, OP_IMM));
    for (int off = 0; off < 4; off++) begin
      bval = 8'($urandom);
      bval[7] = (off % 2 == 0);  // Mix negative and positive bytes.
      prog.push_back(imm_instr({4'h0, bval}, 5'd0, F3_ADD_SUB, 5'd1, OP_IMM));
      prog.push_back(store_instr(12'(16+off), 5'd1, 5'd31, F3_SB));
    end
    for (int off = 0; off < 4; off++) begin
      prog.push_back(imm_instr(12'(16+off), 5'd31, F3_LB, 5'd2, OP_LOAD));
      prog.push_back(store_instr(12'(32+8*off), 5'd2, 5'd31, F3_SW));
      prog.push_back(imm_instr(12'(16+off), 5'd31, F3_LBU, 5'd3, OP_LOAD));
      prog.push_back(store_instr(12'(36+8*off), 5'd3, 5'd31, F3_SW));
    end
    prog.push_back(imm_instr(12'd16, 5'd31, F3_LW, 5'd4, OP_LOAD));
    prog.push_back(store_instr(12'd64, 5'd4, 5'd31, F3_SW));
    prog.push_back(imm_instr(12'h101, 5'd31, F3_LB, 5'd5, OP_LOAD));  // Byte of fill pattern.
    prog.push_back(store_instr(12'd68, 5'd5, 5'd31, F3_SW));
    prog.push_back(jal_instr(21'd0, 5'd0));
  endtask

  task automatic build_branches();
    prog.delete();
    prog.push_back(imm_instr(12'h400, 5'd0, F3_ADD_SUB, 5'd31, OP_IMM));
    prog.push_back(imm_instr(12'd5, 5'd0, F3_ADD_SUB, 5'd1, OP_IMM));
    prog.push_back(imm_instr(12'd5, 5'd0, F3_ADD_SUB, 5'd2, OP_IMM));
    prog.push_back(imm_instr(12'd7, 5'd0, F3_ADD_SUB, 5'd3, OP_IMM));
    prog.push_back(branch_instr(13'd8, 5'd2, 5'd1, F3_BEQ));  // Taken.
    prog.push_back(store_instr(12'd0, 5'd3, 5'd31, F3_SW));
    prog.push_back(store_instr(12'd4, 5'd1, 5'd31, F3_SW));
    prog.push_back(branch_instr(13'd8, 5'd2, 5'd1, F3_BNE));  // Not taken.
    prog.push_back(store_instr(12'd8, 5'd2, 5'd31, F3_SW));
    prog.push_back(branch_instr(13'd8, 5'd3, 5'd1, F3_BNE));
    prog.push_back(store_instr(12'd12, 5'd3, 5'd31, F3_SW));
    prog.push_back(branch_instr(13'd8, 5'd3, 5'd1, F3_BEQ));
    prog.push_back(store_instr(12'd16, 5'd3, 5'd31, F3_SW));
    prog.push_back(jal_instr(21'd8, 5'd5));
    prog.push_back(store_instr(12'd20, 5'd1, 5'd31, F3_SW));
    prog.push_back(store_instr(12'd24, 5'd5, 5'd31, F3_SW));  // Link value.
    prog.push_back(jal_instr(21'd0, 5'd0));
  endtask

  task automatic build_mixed();
    logic [4:0] r;
    prog.delete();
    prog.push_back(imm_instr(12'h400, 5'd0, F3_ADD_SUB, 5'd31, OP_IMM));
    for (int k = 1; k <= 8; k++) begin
      prog.push_back(imm_instr(12'($urandom), 5'd0, F3_ADD_SUB, 5'(k), OP_IMM));
    end
    repeat (40) begin
      r = 5'($urandom_range(30, 1));
      case ($urandom_range(7, 0))
        3: prog.push_back(store_instr(12'(4*$urandom_range(63, 0)), r, 5'd31, F3_SW));
        4: prog.push_back(store_instr(12'($urandom_range(255, 0)), r, 5'd31, F3_SB));
        5: prog.push_back(imm_instr(12'($urandom_range(255, 0)), 5'd31,
                                    $urandom_range(1, 0) ? F3_LB : F3_LBU, r, OP_LOAD));
        6: prog.push_back(branch_instr($urandom_range(1, 0) ? 13'd8 : 13'd12,
                                       5'($urandom_range(8, 0)), 5'($urandom_range(8, 0)),
                                       $urandom_range(1, 0) ? F3_BEQ : F3_BNE));
        7: prog.push_back(jal_instr(21'd8, r));
        default: add_random_alu();
      endcase
    end
    prog.push_back(imm_instr(12'd8, 5'd31, F3_LW, 5'd9, OP_LOAD));
    for (int k = 1; k <= 10; k++) prog.push_back(store_instr(12'(4*k), 5'(k), 5'd31, F3_SW));
    prog.push_back(jal_instr(21'd0, 5'd0));
  endtask

  task automatic load_memory();
    logic [31:0] word;
    for (int i = 0; i < MEM_WORDS; i++) begin
      if (i < prog.size()) word = prog[i];
      else if (i < DATA_WORD) word = 32'h0000_0013;  // NOP.
      else word = (i * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
      mem[i] = word;
      chk0.set_word(i, word);
    end
  endtask

  task automatic run_program(input string name, input bit delay_on);
    int steps;
    int n_exp;
    int err0;
    @(negedge clk);
    rst_n        = 1'b0;
    random_delay = delay_on;
    load_memory();
    steps = chk0.predict_writes(MEM_WORDS);
    n_exp = chk0.expected_total;
    err0  = chk0.error_count + dut0.props0.violations;
    repeat (8) @(negedge clk);
    rst_n    = 1'b1;
    deadline = $time + steps * 160 * 20;  // 40 cycles per instruction, times 4.
    armed    = 1'b1;
    while (chk0.seen_count < n_exp) @(negedge clk);
    repeat (4) @(negedge clk);
    armed = 1'b0;
    if (chk0.error_count + dut0.props0.violations == err0 && chk0.seen_count == n_exp) begin
      pass_count++;
      $display("test %s: %0d writes, pass", name, n_exp);
    end else begin
      fail_count++;
      $display("test %s: %0d writes expected, %0d seen, fail", name, n_exp, chk0.seen_count);
    end
  endtask

  initial begin
    void'($urandom(32'h4f0a));
    rst_n        = 1'b0;
    mem_ack      = 1'b0;
    mem_rdata    = '0;
    random_delay = 1'b0;
    pending      = 1'b0;
    wait_cnt     = 0;
    armed        = 1'b0;
    deadline     = 0;
    pass_count   = 0;
    fail_count   = 0;
    build_arith();
    run_program("arithmetic", 1'b1);
    build_constants();
    run_program("constants", 1'b1);
    build_bytes();
    run_program("byte access", 1'b1);
    build_branches();
    run_program("control flow", 1'b1);
    build_mixed();
    run_program("mixed, zero delay", 1'b0);
    run_program("mixed, random delay", 1'b1);
    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog.f */
logic/rv_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/control_fsm.sv
logic/instr_decode.sv
logic/alu.sv
logic/reg_file.sv
logic/load_store_unit.sv
logic/multicycle_core.sv
verif/core_props.sv
verif/core_checker.sv
verif/core_tb.sv

/* Bender.yml */
package:
  name: multicycle_core

sources:
  - logic/rv_isa_pkg.sv
  - logic/core_ctrl_pkg.sv
  - logic/control_fsm.sv
  - logic/instr_decode.sv
  - logic/alu.sv
  - logic/reg_file.sv
  - logic/load_store_unit.sv
  - logic/multicycle_core.sv
  - target: simulation
    files:
      - verif/core_props.sv
      - verif/core_checker.sv
      - verif/core_tb.sv
